// File: car_row.sv
/*
 * One lane of four evenly spaced cars that wrap around the screen.
 * Reports which frogs overlap a car in the lane's row.
 */
`include "frogger_defines.svh"

module car_row
    import frogger_pkg::*;
#(
    parameter int LANE = 0
)
(
    input  logic                         Clk,
    input  logic                         rst,
    input  logic                         advance,
    input  frog_pos_t [`NUM_FROGS-1:0]   frogs,
    output logic [`NUM_FROGS-1:0]        hit
);

    localparam int     NUM_CARS = 4;
    localparam coord_t SCREEN   = coord_t'(`SCREEN_W);
    localparam coord_t WIDTH    = coord_t'(`GRID);
    localparam coord_t LANE_Y   = coord_t'((LANE == 0) ? `CAR_Y_0 :
                                           (LANE == 1) ? `CAR_Y_1 :
                                           (LANE == 2) ? `CAR_Y_2 : `CAR_Y_3);
    localparam coord_t SPEED    = coord_t'((LANE == 0) ? `CAR_SPEED_0 :
                                           (LANE == 1) ? `CAR_SPEED_1 :
                                           (LANE == 2) ? `CAR_SPEED_2 : `CAR_SPEED_3);
    localparam bit     MOVE_RIGHT = (LANE == 0) ? `CAR_DIR_0 :
                                    (LANE == 1) ? `CAR_DIR_1 :
                                    (LANE == 2) ? `CAR_DIR_2 : `CAR_DIR_3;

    coord_t offset;                 // x of car 0
    coord_t car_x [NUM_CARS];

    // Shortest distance on the wrapped screen
    function automatic coord_t circ_dist(input coord_t a, input coord_t b);
        coord_t d;
        d = (a >= b) ? a - b : b - a;
        return (d > SCREEN - d) ? SCREEN - d : d;
    endfunction

    always_ff @(posedge Clk)
    begin
        if (rst)
            offset <= '0;
        else if (advance)
        begin
            if (MOVE_RIGHT)
                offset <= (offset + SPEED >= SCREEN) ? offset + SPEED - SCREEN : offset + SPEED;
            else
                offset <= (offset < SPEED) ? offset + SCREEN - SPEED : offset - SPEED;
        end
    end

    // Car positions and hit test
    // --------------------
    always_comb
    begin
        for (int k = 0; k < NUM_CARS; k++)
        begin
            car_x[k] = offset + coord_t'(k * `CAR_GAP);
            if (car_x[k] >= SCREEN)
                car_x[k] = car_x[k] - SCREEN;   // Wrap
        end
        hit = '0;
        for (int f = 0; f < `NUM_FROGS; f++)
        begin
            for (int k = 0; k < NUM_CARS; k++)
            begin
                if (frogs[f].y == LANE_Y && circ_dist(frogs[f].x, car_x[k]) < WIDTH)
                    hit[f] = 1'b1;
            end
        end
    end

    a_offset_range: assert property (@(posedge Clk) disable iff (rst) offset < SCREEN);

endmodule

// File: compile.f
+incdir+.
frogger_pkg.sv
key_decoder.sv
car_row.sv
frog.sv
game_state.sv
seg7_decoder.sv
frogger_top.sv
tb_frogger.sv

// File: frog.sv
/*
 * One frog. Steps one grid cell per move strobe while selected, returns
 * to its start when a car hits it and freezes once it reaches home.
 */
`include "frogger_defines.svh"

module frog
    import frogger_pkg::*;
#(
    parameter int INDEX = 0
)
(
    input  logic                                  Clk,
    input  logic                                  rst,
    input  logic                                  advance,
    input  logic                                  playing,
    input  move_t                                 move,
    input  logic [2:0]                            sel,
    input  logic [`NUM_LANES-1:0][`NUM_FROGS-1:0] lane_hit,
    output frog_pos_t                             pos,
    output logic                                  dead,
    output logic                                  home
);

    localparam coord_t START_X = coord_t'((INDEX == 0) ? `FROG_X_0 :
                                          (INDEX == 1) ? `FROG_X_1 : `FROG_X_2);
    localparam coord_t STEP    = coord_t'(`GRID);
    localparam coord_t X_MAX   = coord_t'(`X_MAX);
    localparam coord_t Y_START = coord_t'(`Y_START);
    localparam coord_t Y_GOAL  = coord_t'(`Y_GOAL);

    logic      any_hit;
    frog_pos_t next_pos;

    always_comb
    begin
        any_hit = 1'b0;
        for (int l = 0; l < `NUM_LANES; l++)
            any_hit = any_hit | lane_hit[l][INDEX];
    end

    assign home = (pos.y == Y_GOAL);
    assign dead = advance && any_hit;   // Only on frame ticks

    // Clamped next cell
    // --------------------
    always_comb
    begin
        next_pos = pos;
        case (move.dir)
            DIR_LEFT:  next_pos.x = (pos.x < STEP) ? '0 : pos.x - STEP;
            DIR_RIGHT: next_pos.x = (pos.x + STEP > X_MAX) ? X_MAX : pos.x + STEP;
            DIR_UP:    next_pos.y = (pos.y < Y_GOAL + STEP) ? Y_GOAL : pos.y - STEP;
            DIR_DOWN:  next_pos.y = (pos.y + STEP > Y_START) ? Y_START : pos.y + STEP;
            default:   next_pos = pos;
        endcase
    end

    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            pos.x <= START_X;
            pos.y <= Y_START;
        end
        else if (dead)
        begin
            pos.x <= START_X;   // Hit wins over a move
            pos.y <= Y_START;
        end
        else if (move.valid && sel[INDEX] && playing && !home)
        begin
            pos <= next_pos;
        end
    end

    a_pos_bounds: assert property (@(posedge Clk) disable iff (rst)
        pos.x <= X_MAX && pos.y >= Y_GOAL && pos.y <= Y_START);

endmodule

// File: frogger_defines.svh
/*
 * Screen, grid, lane, timer and keycode constants of the Frogger game core.
 * Included by every RTL file that needs a game constant.
 */
`ifndef FROGGER_DEFINES_SVH
`define FROGGER_DEFINES_SVH

`define SCREEN_W      640     // Lane wrap width
`define GRID          40      // Frog step, car and frog width
`define X_MAX         600
`define Y_START       440     // Frog start row
`define Y_GOAL        40      // Home row
`define NUM_LANES     4
`define NUM_FROGS     3

`define CAR_Y_0       400
`define CAR_Y_1       360
`define CAR_Y_2       320
`define CAR_Y_3       280
`define CAR_SPEED_0   10      // Pixels per frame
`define CAR_SPEED_1   7
`define CAR_SPEED_2   3
`define CAR_SPEED_3   1
`define CAR_DIR_0     1'b1    // 1 moves right, 0 moves left
`define CAR_DIR_1     1'b0
`define CAR_DIR_2     1'b1
`define CAR_DIR_3     1'b0
`define CAR_GAP       160

`define FROG_X_0      120
`define FROG_X_1      320
`define FROG_X_2      520

`define LIVES_INIT    5
`define TIME_INIT     60      // Seconds
`define TICKS_PER_SEC 60

// USB HID keycodes
`define KEY_LEFT      8'h50
`define KEY_RIGHT     8'h4f
`define KEY_UP        8'h52
`define KEY_DOWN      8'h51
`define KEY_FROG_0    8'h59
`define KEY_FROG_1    8'h5a
`define KEY_FROG_2    8'h5b

`endif

// File: frogger_pkg.sv
/*
 * Shared types of the Frogger game core: coordinates, moves, counters
 * and the game state machine encoding.
 */
package frogger_pkg;

    typedef logic [10:0] coord_t;   // Pixel coordinate

    typedef struct packed
    {
        coord_t x;
        coord_t y;
    } frog_pos_t;

    typedef enum logic [1:0]
    {
        DIR_LEFT,
        DIR_RIGHT,
        DIR_UP,
        DIR_DOWN
    } dir_t;

    // One-cycle move strobe with its direction
    typedef struct packed
    {
        logic valid;
        dir_t dir;
    } move_t;

    typedef logic [3:0] lives_t;
    typedef logic [6:0] time_t;     // Seconds left

    typedef struct packed
    {
        logic win;
        logic lose;
    } game_status_t;

    typedef enum logic [1:0]
    {
        PLAYING,
        WON,
        LOST
    } game_fsm_t;

endpackage

// File: frogger_top.sv
/*
 * Frogger game core. Takes a keycode and a frame tick, reports frog
 * positions, win and lose status and the time and lives displays.
 */
`include "frogger_defines.svh"

module frogger_top
    import frogger_pkg::*;
(
    input  logic                         Clk,
    input  logic                         rst,
    input  logic [7:0]                   keycode,
    input  logic                         frame_tick,
    output frog_pos_t [`NUM_FROGS-1:0]   frogs,
    output game_status_t                 status,
    output logic [6:0]                   hex_time_ones,
    output logic [6:0]                   hex_time_tens,
    output logic [6:0]                   hex_lives
);

    move_t                                 move;
    logic [2:0]                            sel;
    logic                                  advance;
    logic                                  playing;
    logic [`NUM_LANES-1:0][`NUM_FROGS-1:0] lane_hit;
    logic [`NUM_FROGS-1:0]                 dead;
    logic [`NUM_FROGS-1:0]                 home;
    lives_t                                lives;
    time_t                                 time_left;
    logic [3:0]                            time_tens;
    logic [3:0]                            time_ones;

    key_decoder i_key_decoder (.Clk, .rst, .keycode, .move, .sel);

    // Lanes and frogs
    // --------------------
    for (genvar l = 0; l < `NUM_LANES; l++)
    begin : g_lane
        car_row #(.LANE(l)) i_car_row (
            .Clk, .rst, .advance, .frogs, .hit(lane_hit[l])
        );
    end

    for (genvar f = 0; f < `NUM_FROGS; f++)
    begin : g_frog
        frog #(.INDEX(f)) i_frog (
            .Clk, .rst, .advance, .playing, .move, .sel, .lane_hit,
            .pos(frogs[f]), .dead(dead[f]), .home(home[f])
        );
    end

    game_state i_game_state (
        .Clk, .rst, .frame_tick, .dead, .home,
        .advance, .playing, .lives, .time_left, .status
    );

    // Displays
    // --------------------
    assign time_tens = 4'(time_left / 7'd10);
    assign time_ones = 4'(time_left % 7'd10);

    seg7_decoder i_seg_ones  (.digit(time_ones), .seg(hex_time_ones));
    seg7_decoder i_seg_tens  (.digit(time_tens), .seg(hex_time_tens));
    seg7_decoder i_seg_lives (.digit(lives),     .seg(hex_lives));

endmodule

// File: game_state.sv
/*
 * Game bookkeeping: life counter, per-second countdown and the
 * play/won/lost state machine. Gates the frame tick into advance.
 */
`include "frogger_defines.svh"

module game_state
    import frogger_pkg::*;
(
    input  logic                  Clk,
    input  logic                  rst,
    input  logic                  frame_tick,
    input  logic [`NUM_FROGS-1:0] dead,
    input  logic [`NUM_FROGS-1:0] home,
    output logic                  advance,
    output logic                  playing,
    output lives_t                lives,
    output time_t                 time_left,
    output game_status_t          status
);

    localparam int TICK_W = $clog2(`TICKS_PER_SEC);

    game_fsm_t         state;
    logic [TICK_W-1:0] tick_cnt;
    logic [TICK_W-1:0] tick_next;
    logic [1:0]        dead_count;
    lives_t            lives_next;
    time_t             time_next;
    logic              sec_done;

    assign playing = (state == PLAYING);
    assign advance = frame_tick && playing; // Frozen after win or loss

    always_comb
    begin
        dead_count = 2'(dead[0]) + 2'(dead[1]) + 2'(dead[2]);
        lives_next = (lives > lives_t'(dead_count)) ? lives - lives_t'(dead_count) : '0;
        sec_done   = (tick_cnt == TICK_W'(`TICKS_PER_SEC - 1));
        tick_next  = sec_done ? '0 : tick_cnt + 1'b1;
        time_next  = (sec_done && time_left != '0) ? time_left - 1'b1 : time_left;
    end

    // State, counters and status
    // --------------------
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            state     <= PLAYING;
            status    <= '0;
            lives     <= lives_t'(`LIVES_INIT);
            time_left <= time_t'(`TIME_INIT);
            tick_cnt  <= '0;
        end
        else if (advance)
        begin
            lives     <= lives_next;
            time_left <= time_next;
            tick_cnt  <= tick_next;
            if (&home)
            begin
                state      <= WON;  // Win beats a loss on the same tick
                status.win <= 1'b1;
            end
            else if (lives_next == '0 || time_next == '0)
            begin
                state       <= LOST;
                status.lose <= 1'b1;
            end
        end
    end

    a_lives_max: assert property (@(posedge Clk) disable iff (rst)
        lives <= lives_t'(`LIVES_INIT));

endmodule

// File: key_decoder.sv
/*
 * Keyboard decoder. Arrow keys give one move strobe per new press,
 * frog keys latch a one-hot frog selection for the next cycle.
 */
`include "frogger_defines.svh"

module key_decoder
    import frogger_pkg::*;
(
    input  logic        Clk,
    input  logic        rst,
    input  logic [7:0]  keycode,
    output move_t       move,
    output logic [2:0]  sel
);

    logic [7:0] keycode_prev;   // Keycode seen last cycle
    logic       is_arrow;

    // Move strobe
    // --------------------
    always_comb
    begin
        is_arrow = 1'b1;
        move.dir = DIR_LEFT;
        case (keycode)
            `KEY_LEFT:  move.dir = DIR_LEFT;
            `KEY_RIGHT: move.dir = DIR_RIGHT;
            `KEY_UP:    move.dir = DIR_UP;
            `KEY_DOWN:  move.dir = DIR_DOWN;
            default:    is_arrow = 1'b0;
        endcase
        move.valid = is_arrow && (keycode != keycode_prev); // Held key gives no repeat
    end

    // Registered key history and selection
    // --------------------
    always_ff @(posedge Clk)
    begin
        if (rst)
        begin
            keycode_prev <= '0;
            sel          <= '0;
        end
        else
        begin
            keycode_prev <= keycode;
            case (keycode)
                `KEY_FROG_0: sel <= 3'b001;
                `KEY_FROG_1: sel <= 3'b010;
                `KEY_FROG_2: sel <= 3'b100;
                default:     sel <= sel;    // Zero and other codes keep the choice
            endcase
        end
    end

    a_sel_onehot: assert property (@(posedge Clk) disable iff (rst) $onehot0(sel));

endmodule

// File: run.sh
#!/bin/sh
# Compiles the Frogger core testbench with Verilator, runs it and looks for the pass line
verilator --binary -j 0 --assert -Wno-fatal --top-module tb_frogger -f compile.f -o tb_frogger \
    && out=$(./obj_dir/tb_frogger) \
    && echo "$out" \
    && echo "$out" | grep -qF '** PASS **' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: seg7_decoder.sv
/*
 * Hex digit to active-low seven-segment pattern, bit order gfedcba.
 */
module seg7_decoder
(
    input  logic [3:0] digit,
    output logic [6:0] seg
);

    always_comb
    begin
        case (digit)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            4'ha: seg = 7'b0001000;
            4'hb: seg = 7'b0000011; // Lower case b
            4'hc: seg = 7'b1000110;
            4'hd: seg = 7'b0100001; // Lower case d
            4'he: seg = 7'b0000110;
            default: seg = 7'b0001110;
        endcase
    end

endmodule

// File: tb_frogger_model.svh
/*
 * Reference model of the Frogger game core, included inside the testbench
 * module. Call model_reset or model_step once per rising clock edge.
 */
`ifndef TB_FROGGER_MODEL_SVH
`define TB_FROGGER_MODEL_SVH

localparam int LANE_Y [4]     = '{`CAR_Y_0, `CAR_Y_1, `CAR_Y_2, `CAR_Y_3};
localparam int LANE_SPEED [4] = '{`CAR_SPEED_0, `CAR_SPEED_1, `CAR_SPEED_2, `CAR_SPEED_3};
localparam bit LANE_RIGHT [4] = '{`CAR_DIR_0, `CAR_DIR_1, `CAR_DIR_2, `CAR_DIR_3};
localparam int START_X [3]    = '{`FROG_X_0, `FROG_X_1, `FROG_X_2};

// Active low in gfedcba bit order
localparam logic [6:0] SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
};

int         m_offset [4];   // x of car 0 in each lane
int         m_x [3];
int         m_y [3];
logic [2:0] m_sel;
logic [7:0] m_prev_key;
int         m_lives;
int         m_time;
int         m_ticks;        // Frame ticks within the current second
bit         m_win;
bit         m_lose;

function automatic bit car_hits(input int lane, input int fx, input int fy);
    int cx;
    int d;
    if (fy != LANE_Y[lane])
        return 1'b0;
    for (int k = 0; k < 4; k++)
    begin
        cx = (m_offset[lane] + k * `CAR_GAP) % `SCREEN_W;
        d  = (fx - cx + `SCREEN_W) % `SCREEN_W;    // Distance to the right of the car
        if (d < `GRID || d > `SCREEN_W - `GRID)
            return 1'b1;
    end
    return 1'b0;
endfunction

task automatic model_reset();
    for (int l = 0; l < 4; l++)
        m_offset[l] = 0;
    for (int f = 0; f < 3; f++)
    begin
        m_x[f] = START_X[f];
        m_y[f] = `Y_START;
    end
    m_sel      = 3'b000;
    m_prev_key = 8'h00;
    m_lives    = `LIVES_INIT;
    m_time     = `TIME_INIT;
    m_ticks    = 0;
    m_win      = 1'b0;
    m_lose     = 1'b0;
endtask

task automatic model_step(input logic [7:0] key, input logic tick);
    bit adv;
    bit valid;
    bit all_home;
    bit hit [3];
    int n_dead;
    adv      = tick && !m_win && !m_lose;
    valid    = (key inside {`KEY_LEFT, `KEY_RIGHT, `KEY_UP, `KEY_DOWN}) && key != m_prev_key;
    all_home = 1'b1;
    n_dead   = 0;

    // Hits and home from the state before this edge
    // --------------------
    for (int f = 0; f < 3; f++)
    begin
        hit[f] = 1'b0;
        for (int l = 0; l < 4; l++)
            hit[f] = hit[f] | car_hits(l, m_x[f], m_y[f]);
        if (m_y[f] != `Y_GOAL)
            all_home = 1'b0;
    end

    for (int f = 0; f < 3; f++)
    begin
        if (adv && hit[f])
        begin
            n_dead = n_dead + 1;
            m_x[f] = START_X[f];
            m_y[f] = `Y_START;
        end
        else if (valid && m_sel[f] && !m_win && !m_lose && m_y[f] != `Y_GOAL)
        begin
            case (key)
                `KEY_LEFT:  m_x[f] = (m_x[f] - `GRID < 0) ? 0 : m_x[f] - `GRID;
                `KEY_RIGHT: m_x[f] = (m_x[f] + `GRID > `X_MAX) ? `X_MAX : m_x[f] + `GRID;
                `KEY_UP:    m_y[f] = (m_y[f] - `GRID < `Y_GOAL) ? `Y_GOAL : m_y[f] - `GRID;
                default:    m_y[f] = (m_y[f] + `GRID > `Y_START) ? `Y_START : m_y[f] + `GRID;
            endcase
        end
    end

    case (key)
        `KEY_FROG_0: m_sel = 3'b001;
        `KEY_FROG_1: m_sel = 3'b010;
        `KEY_FROG_2: m_sel = 3'b100;
        default:     ;
    endcase
    m_prev_key = key;

    if (adv)
    begin
        for (int l = 0; l < 4; l++)
            m_offset[l] = LANE_RIGHT[l] ? (m_offset[l] + LANE_SPEED[l]) % `SCREEN_W
                                        : (m_offset[l] - LANE_SPEED[l] + `SCREEN_W) % `SCREEN_W;
        m_lives = (m_lives > n_dead) ? m_lives - n_dead : 0;
        m_ticks = m_ticks + 1;
        if (m_ticks == `TICKS_PER_SEC)
        begin
            m_ticks = 0;
            if (m_time > 0)
                m_time = m_time - 1;
        end
        if (all_home)
            m_win = 1'b1;   // Win first
        else if (m_lives == 0 || m_time == 0)
            m_lose = 1'b1;
    end
endtask

`endif

// File: tb_frogger.sv
/*
 * Testbench of the Frogger game core. LFSR driven keys and frame ticks go
 * to the DUT, and every cycle its outputs are compared with the model.
 */
`include "frogger_defines.svh"

module tb_frogger
    import frogger_pkg::*;
();

    localparam int PERIOD         = 100;
    localparam int RESET_CYCLES   = 2;
    localparam int MOVE_CYCLES    = 400;
    localparam int COLLIDE_CYCLES = 1500;
    localparam int HOME_CYCLES    = 3 * 24 + 200;   // Scripted climb before the random part
    localparam int COUNT_CYCLES   = `TIME_INIT * `TICKS_PER_SEC + 100;
    localparam int TOTAL_CYCLES   = 4 * (RESET_CYCLES + 1) + MOVE_CYCLES + COLLIDE_CYCLES
                                    + HOME_CYCLES + COUNT_CYCLES;
    localparam int MARGIN         = 50;

    logic                       Clk;
    logic                       rst;
    logic [7:0]                 keycode;
    logic                       frame_tick;
    frog_pos_t [`NUM_FROGS-1:0] frogs;
    game_status_t               status;
    logic [6:0]                 hex_time_ones;
    logic [6:0]                 hex_time_tens;
    logic [6:0]                 hex_lives;

    logic [31:0] lfsr;
    int          errors;
    int          checks;
    string       test_name;

`include "tb_frogger_model.svh"

    frogger_top i_frogger_top (
        .Clk, .rst, .keycode, .frame_tick, .frogs, .status,
        .hex_time_ones, .hex_time_tens, .hex_lives
    );

    always #(PERIOD / 2) Clk = ~Clk;

    // Stimulus helpers
    // --------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
    endfunction

    task automatic random_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
    endtask

    function automatic logic [7:0] arrow_code(input int i);
        case (i)
            0:       return `KEY_LEFT;
            1:       return `KEY_RIGHT;
            2:       return `KEY_UP;
            default: return `KEY_DOWN;
        endcase
    endfunction

    function automatic logic [7:0] frog_code(input int i);
        case (i)
            0:       return `KEY_FROG_0;
            1:       return `KEY_FROG_1;
            default: return `KEY_FROG_2;
        endcase
    endfunction

    task automatic apply_reset();
        rst        <= 1'b1;
        keycode    <= 8'h00;
        frame_tick <= 1'b0;
        repeat (RESET_CYCLES) @(posedge Clk);
        rst <= 1'b0;
    endtask

    // Key mode 0 random, 1 silent, 2 arrows are always up
    task automatic drive_random(input int tick_weight, input int key_mode);
        int         pick;
        int         arg;
        logic [7:0] key;
        random_bits(3, pick);
        key = keycode;              // Held by default
        if (key_mode == 1)
            key = 8'h00;
        else if (pick == 3 || pick == 4)
        begin
            random_bits(2, arg);
            key = (key_mode == 2) ? `KEY_UP : arrow_code(arg);
        end
        else if (pick == 5)
        begin
            random_bits(2, arg);
            key = frog_code(arg);
        end
        else if (pick == 6)
            key = 8'h00;
        else if (pick == 7)
        begin
            random_bits(8, arg);
            key = arg[7:0];
        end
        random_bits(2, arg);
        keycode    <= key;
        frame_tick <= (arg < tick_weight);
    endtask

    task automatic run_random(input int cycles, input int tick_weight, input int key_mode);
        repeat (cycles)
        begin
            @(posedge Clk);
            drive_random(tick_weight, key_mode);
        end
    endtask

    task automatic press(input logic [7:0] key);
        @(posedge Clk);
        keycode    <= key;
        frame_tick <= 1'b0;
    endtask

    // Checking
    // --------------------
    task automatic check_value(input string what, input int expected, input int actual);
        checks = checks + 1;
        if (expected != actual)
        begin
            errors = errors + 1;
            $display("Mismatch in %s: %s expected %0d, actual %0d",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic compare_outputs();
        for (int f = 0; f < `NUM_FROGS; f++)
        begin
            check_value($sformatf("frog%0d x", f), m_x[f], int'(frogs[f].x));
            check_value($sformatf("frog%0d y", f), m_y[f], int'(frogs[f].y));
        end
        check_value("win", int'(m_win), int'(status.win));
        check_value("lose", int'(m_lose), int'(status.lose));
        check_value("time tens seg", int'(SEG_TABLE[m_time / 10]), int'(hex_time_tens));
        check_value("time ones seg", int'(SEG_TABLE[m_time % 10]), int'(hex_time_ones));
        check_value("lives seg", int'(SEG_TABLE[m_lives]), int'(hex_lives));
    endtask

    always @(posedge Clk)
    begin
        if (rst)
            model_reset();
        else
            model_step(keycode, frame_tick);
    end

    always @(negedge Clk)
    begin
        if (!rst)
            compare_outputs();
    end

    // Phases
    // --------------------
    initial
    begin
        rst        = 1'b1;
        Clk        = 1'b0;
        keycode    = 8'h00;
        frame_tick = 1'b0;
        lfsr       = 32'h7028;
        errors     = 0;
        checks     = 0;

        test_name = "select_move";
        apply_reset();
        run_random(MOVE_CYCLES, 0, 0);      // Keys only without frame ticks

        test_name = "collide";
        @(posedge Clk);
        apply_reset();
        run_random(COLLIDE_CYCLES, 2, 2);
        if (m_lives == `LIVES_INIT)
        begin
            errors = errors + 1;
            $display("collide: no frog was hit by a car");
        end

        test_name = "home_win";
        @(posedge Clk);
        apply_reset();
        for (int f = 0; f < `NUM_FROGS; f++)
        begin
            press(frog_code(f));
            press(8'h00);
            repeat (10)
            begin
                press(`KEY_UP);
                press(8'h00);
            end
            press(`KEY_DOWN);               // Frog at home must not leave
            press(8'h00);
        end
        run_random(HOME_CYCLES - 3 * 24, 2, 0);
        @(negedge Clk);
        if (status.win !== 1'b1)
        begin
            errors = errors + 1;
            $display("home_win: status shows no win with all three frogs home");
        end

        test_name = "countdown";
        @(posedge Clk);
        apply_reset();
        run_random(COUNT_CYCLES, 4, 1);     // Tick every cycle
        @(negedge Clk);
        if (status.lose !== 1'b1)
        begin
            errors = errors + 1;
            $display("countdown: status shows no loss after the time ran out");
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial
    begin
        #((TOTAL_CYCLES + MARGIN) * PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", TOTAL_CYCLES + MARGIN);
        $display("** FAIL **");
        $finish;
    end

endmodule
